// File: sim.f
sched_pkg.sv
queue_if.sv
timer_if.sv
ready_queue.sv
delay_timer.sv
dispatcher.sv
rtos_sched.sv
rtos_sched_chk.sv
tb_rtos_sched.sv

// File: tb_rtos_sched.sv
// random command rounds against a task-level model of the scheduler
// model issues only legal commands and never one together with tick
// every tick is followed by enough quiet cycles to drain all wake-ups

`timescale 1ns/1ps
`default_nettype none

module tb_rtos_sched;
    import sched_pkg::*;

    localparam int ROUNDS      = 400;
    localparam int SEED        = 14856;
    localparam int WATCHDOG_NS = ROUNDS * 40 * 8 * 2;

    localparam int ST_IDLE  = 0;
    localparam int ST_READY = 1;
    localparam int ST_SLEEP = 2;

    logic                   clk;
    logic                   reset;
    logic [CMD_WIDTH-1:0]   cmd;
    logic                   cmd_valid;
    logic                   tick;
    wire [ID_WIDTH-1:0]     run_id;
    wire [PRI_WIDTH-1:0]    run_pri;
    wire                    run_valid;
    wire [COUNT_WIDTH-1:0]  ready_count;

    // reference model
    int                   state      [QUE_SIZE];
    logic [PRI_WIDTH-1:0] model_pri  [QUE_SIZE];
    int                   cnt        [QUE_SIZE];
    logic [ID_WIDTH-1:0]  ready_list [$];   // sorted and stable among equal pri

    int checks;
    int errors;

    rtos_sched rtos_sched_inst (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .cmd_valid   (cmd_valid),
        .tick        (tick),
        .run_id      (run_id),
        .run_pri     (run_pri),
        .run_valid   (run_valid),
        .ready_count (ready_count)
    );

    always #4 clk = ~clk;

    // ----------------------------------------------------------------------
    // model helpers
    // ----------------------------------------------------------------------
    task automatic insert_ready(input int id);
        int k;
        k = 0;
        while (k < ready_list.size() && model_pri[ready_list[k]] <= model_pri[id]) begin
            k++;   // behind equal priorities
        end
        ready_list.insert(k, ID_WIDTH'(id));
        state[id] = ST_READY;
    endtask

    task automatic drop_ready(input int id);
        for (int k = 0; k < ready_list.size(); k++) begin
            if (ready_list[k] == id) begin
                ready_list.delete(k);
                break;
            end
        end
    endtask

    function automatic int pick_id(input int want);
        int cand [$];
        for (int i = 0; i < QUE_SIZE; i++) begin
            if (state[i] == want) begin
                cand.push_back(i);
            end
        end
        if (cand.size() == 0) begin
            return -1;
        end
        return cand[$urandom_range(cand.size() - 1, 0)];
    endfunction

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic send_cmd(input sched_cmd_t c);
        cmd       = c;
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = CMD_WIDTH'($urandom);   // junk while not valid
    endtask

    task automatic random_command();
        sched_cmd_t c;
        int         sel;
        int         id;
        c   = sched_cmd_t'(CMD_WIDTH'($urandom));
        sel = $urandom_range(9, 0);   // 0-4 ready, 5-6 exit, 7-8 sleep, 9 nop
        id  = -1;
        if (sel < 5) begin
            id = pick_id(ST_IDLE);
        end else if (sel < 9) begin
            id = pick_id(ST_READY);
        end
        if (id < 0) begin
            c.rdy.op = OP_NOP;
        end else if (sel < 5) begin
            c.rdy.op      = OP_READY;
            c.rdy.id      = ID_WIDTH'(id);
            c.rdy.pri     = PRI_WIDTH'($urandom_range(7, 0));   // narrow range for more ties
            model_pri[id] = c.rdy.pri;
            insert_ready(id);
        end else if (sel < 7) begin
            c.rdy.op  = OP_EXIT;
            c.rdy.id  = ID_WIDTH'(id);
            state[id] = ST_IDLE;
            drop_ready(id);
        end else begin
            c.slp.op    = OP_SLEEP;
            c.slp.id    = ID_WIDTH'(id);
            c.slp.delay = DELAY_WIDTH'($urandom_range(3, 0));
            state[id]   = ST_SLEEP;
            cnt[id]     = c.slp.delay;
            drop_ready(id);
        end
        send_cmd(c);
    endtask

    task automatic tick_and_wake();
        int woke [$];
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
        for (int i = 0; i < QUE_SIZE; i++) begin
            if (state[i] == ST_SLEEP) begin
                if (cnt[i] == 0) begin
                    woke.push_back(i);
                end else begin
                    cnt[i]--;
                end
            end
        end
        repeat (20) @(negedge clk);
        foreach (woke[k]) begin
            insert_ready(woke[k]);   // ascending id order
        end
    endtask

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    task automatic compare_state();
        int exp_count;
        exp_count = ready_list.size();
        checks++;
        assert (ready_count == exp_count) else begin
            errors++;
            $display("error: %0t ready_count expected %0d actual %0d",
                     $time, exp_count, ready_count);
        end
        assert (run_valid == (exp_count != 0)) else begin
            errors++;
            $display("error: %0t run_valid expected %0d actual %0d",
                     $time, exp_count != 0, run_valid);
        end
        if (exp_count != 0) begin
            assert (run_id == ready_list[0]) else begin
                errors++;
                $display("error: %0t run_id expected %0d actual %0d",
                         $time, ready_list[0], run_id);
            end
            assert (run_pri == model_pri[ready_list[0]]) else begin
                errors++;
                $display("error: %0t run_pri expected %0d actual %0d",
                         $time, model_pri[ready_list[0]], run_pri);
            end
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("error: run did not finish within %0d ns", WATCHDOG_NS);
        $display("SOME TESTS FAILED");
        $finish;
    end

    initial begin
        int n_cmds;
        int assert_errors;
        void'($urandom(SEED));
        clk       = 1'b0;
        reset     = 1'b1;
        cmd       = '0;
        cmd_valid = 1'b0;
        tick      = 1'b0;
        checks    = 0;
        errors    = 0;
        for (int i = 0; i < QUE_SIZE; i++) begin
            state[i]     = ST_IDLE;
            model_pri[i] = '0;
            cnt[i]       = 0;
        end
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        compare_state();   // empty after reset

        for (int r = 0; r < ROUNDS; r++) begin
            n_cmds = $urandom_range(8, 1);
            for (int j = 0; j < n_cmds; j++) begin
                random_command();
                if ($urandom_range(3, 0) == 0) begin
                    repeat ($urandom_range(2, 1)) @(negedge clk);
                end
            end
            repeat (2) @(negedge clk);
            compare_state();
            if ($urandom_range(1, 0) == 1) begin
                tick_and_wake();
                compare_state();
            end
        end

        assert_errors = rtos_sched_inst.rtos_sched_chk_inst.fail_count;
        $display("checks %0d, value errors %0d, assertion errors %0d",
                 checks, errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rtos_sched_chk.sv
// output checks for the task scheduler bound into rtos_sched
// all properties sample on the rising clock edge

`timescale 1ns/1ps
`default_nettype none

module rtos_sched_chk (
    input wire                              clk,
    input wire                              reset,
    input wire                              run_valid,
    input wire [sched_pkg::COUNT_WIDTH-1:0] ready_count
);
    import sched_pkg::*;

    int fail_count;   // read by the testbench at the end

    initial fail_count = 0;

    // head valid exactly when the queue holds a task
    valid_matches_count: assert property (
        @(posedge clk) disable iff (reset) run_valid == (ready_count != '0)
    ) else begin
        fail_count++;
        $error("run_valid does not match a nonzero ready_count");
    end

    count_in_range: assert property (
        @(posedge clk) disable iff (reset) ready_count <= COUNT_WIDTH'(QUE_SIZE)
    ) else begin
        fail_count++;
        $error("ready_count exceeds the number of tasks");
    end

    idle_after_reset: assert property (
        @(posedge clk) reset |=> !run_valid
    ) else begin
        fail_count++;
        $error("run_valid high in the cycle after reset");
    end

endmodule

bind rtos_sched rtos_sched_chk rtos_sched_chk_inst (
    .clk         (clk),
    .reset       (reset),
    .run_valid   (run_valid),
    .ready_count (ready_count)
);

`default_nettype wire

// File: rtos_sched.sv
// hardware task scheduler, 16 tasks
// one command per cycle, no command in the same cycle as tick
// run outputs show the head of the ready queue
// run_id and run_pri are meaningful only while run_valid is high

`timescale 1ns/1ps
`default_nettype none

module rtos_sched (
    input  wire                                clk,
    input  wire                                reset,
    input  wire [sched_pkg::CMD_WIDTH-1:0]     cmd,
    input  wire                                cmd_valid,
    input  wire                                tick,
    output wire [sched_pkg::ID_WIDTH-1:0]      run_id,
    output wire [sched_pkg::PRI_WIDTH-1:0]     run_pri,
    output wire                                run_valid,
    output wire [sched_pkg::COUNT_WIDTH-1:0]   ready_count
);
    import sched_pkg::*;

    sched_cmd_t cmd_word;

    queue_if q_if ();
    timer_if t_if ();

    assign cmd_word = sched_cmd_t'(cmd);

    // ----------------------------------------------------------------------
    // blocks
    // ----------------------------------------------------------------------
    dispatcher dispatcher_inst (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd_word),
        .cmd_valid (cmd_valid),
        .q         (q_if.dispatch),
        .t         (t_if.dispatch)
    );

    ready_queue ready_queue_inst (
        .clk   (clk),
        .reset (reset),
        .q     (q_if.queue)
    );

    delay_timer delay_timer_inst (
        .clk   (clk),
        .reset (reset),
        .tick  (tick),
        .t     (t_if.timer)
    );

    assign run_id      = q_if.top_id;
    assign run_pri     = q_if.top_pri;
    assign run_valid   = q_if.top_valid;
    assign ready_count = q_if.count;

endmodule

`default_nettype wire

// File: dispatcher.sv
// command decoder between host, ready queue and delay timer
// READY adds to the queue and records the priority of the task
// SLEEP removes from the queue and arms the timer at that priority
// EXIT removes from the queue
// wake-ups are taken only in cycles without a command
// command legality is left to the host

`timescale 1ns/1ps
`default_nettype none

module dispatcher (
    input wire                     clk,
    input wire                     reset,
    input wire sched_pkg::sched_cmd_t cmd,
    input wire                     cmd_valid,
    queue_if.dispatch              q,
    timer_if.dispatch              t
);
    import sched_pkg::*;

    logic [PRI_WIDTH-1:0] pri_tbl [QUE_SIZE];

    logic is_ready;
    logic is_sleep;
    logic is_exit;
    logic is_idle;

    // ----------------------------------------------------------------------
    // decode
    // ----------------------------------------------------------------------
    assign is_ready = cmd_valid && (cmd.rdy.op == OP_READY);
    assign is_sleep = cmd_valid && (cmd.slp.op == OP_SLEEP);
    assign is_exit  = cmd_valid && (cmd.rdy.op == OP_EXIT);
    assign is_idle  = !(is_ready || is_sleep || is_exit);   // NOP counts as idle

    always_comb begin
        q.add_id       = cmd.rdy.id;
        q.add_pri      = cmd.rdy.pri;
        q.add_valid    = is_ready;
        q.remove_id    = cmd.rdy.id;
        q.remove_valid = is_sleep || is_exit;
        t.wake_ack     = 1'b0;

        // free slot in the queue port, take one wake-up
        if (is_idle && t.wake_valid) begin
            q.add_id    = t.wake_id;
            q.add_pri   = t.wake_pri;
            q.add_valid = 1'b1;
            t.wake_ack  = 1'b1;
        end
    end

    assign t.sleep_id    = cmd.slp.id;
    assign t.sleep_delay = cmd.slp.delay;
    assign t.sleep_pri   = pri_tbl[cmd.slp.id];
    assign t.sleep_valid = is_sleep;

    // ----------------------------------------------------------------------
    // priority table
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < QUE_SIZE; i++) begin
                pri_tbl[i] <= '0;
            end
        end else if (is_ready) begin
            pri_tbl[cmd.rdy.id] <= cmd.rdy.pri;
        end
    end

endmodule

`default_nettype wire

// File: delay_timer.sv
// per-task sleep countdown with ordered wake-up reporting
// a task armed with delay d becomes pending on the (d+1)-th tick
// lowest pending id is shown first, held steady until acknowledged
// sleep and tick must not arrive in the same cycle

`timescale 1ns/1ps
`default_nettype none

module delay_timer (
    input wire     clk,
    input wire     reset,
    input wire     tick,
    timer_if.timer t
);
    import sched_pkg::*;

    logic [DELAY_WIDTH-1:0] cnt_q [QUE_SIZE];
    logic [PRI_WIDTH-1:0]   pri_q [QUE_SIZE];
    logic [QUE_SIZE-1:0]    armed_q;
    logic [QUE_SIZE-1:0]    pend_q;

    logic                   held_q;      // wake shown last cycle, not yet taken
    logic [ID_WIDTH-1:0]    held_id_q;
    logic [ID_WIDTH-1:0]    low_id;

    // ----------------------------------------------------------------------
    // wake-up selection
    // ----------------------------------------------------------------------
    always_comb begin
        low_id = '0;
        for (int i = QUE_SIZE - 1; i >= 0; i--) begin
            if (pend_q[i]) begin
                low_id = ID_WIDTH'(i);
            end
        end
    end

    assign t.wake_valid = |pend_q;
    assign t.wake_id    = held_q ? held_id_q : low_id;   // no swap while waiting
    assign t.wake_pri   = pri_q[t.wake_id];

    // ----------------------------------------------------------------------
    // control bits
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            armed_q <= '0;
            pend_q  <= '0;
            held_q  <= 1'b0;
        end else begin
            held_q <= t.wake_valid && !t.wake_ack;
            if (t.wake_ack) begin
                pend_q[t.wake_id] <= 1'b0;
            end
            if (tick) begin
                for (int i = 0; i < QUE_SIZE; i++) begin
                    if (armed_q[i] && cnt_q[i] == '0) begin
                        armed_q[i] <= 1'b0;
                        pend_q[i]  <= 1'b1;
                    end
                end
            end
            if (t.sleep_valid) begin
                armed_q[t.sleep_id] <= 1'b1;
            end
        end
    end

    // counters and latched priorities
    always_ff @(posedge clk) begin
        held_id_q <= t.wake_id;
        if (tick) begin
            for (int i = 0; i < QUE_SIZE; i++) begin
                if (armed_q[i] && cnt_q[i] != '0) begin
                    cnt_q[i] <= cnt_q[i] - 1'b1;
                end
            end
        end
        if (t.sleep_valid) begin
            cnt_q[t.sleep_id] <= t.sleep_delay;
            pri_q[t.sleep_id] <= t.sleep_pri;
        end
    end

endmodule

`default_nettype wire

// File: ready_queue.sv
// priority-sorted ready queue of task ids, shift-insert style
// head and count update on the operation edge, deeper slots one edge later
// one add or remove per cycle, equal priorities keep arrival order
// caller must not add beyond QUE_SIZE entries or add an id twice
// removing an absent id is ignored

`timescale 1ns/1ps
`default_nettype none

module ready_queue (
    input wire    clk,
    input wire    reset,
    queue_if.queue q
);
    import sched_pkg::*;

    // registered slots, not yet settled
    logic [ID_WIDTH-1:0]    id_q    [QUE_SIZE];
    logic [PRI_WIDTH-1:0]   pri_q   [QUE_SIZE];
    logic                   valid_q [QUE_SIZE];
    logic [1:0]             flag_q  [QUE_SIZE];
    logic [ID_WIDTH-1:0]    ins_id_q;
    logic [PRI_WIDTH-1:0]   ins_pri_q;
    logic [COUNT_WIDTH-1:0] count_q;

    // settled view after pending shifts
    logic [ID_WIDTH-1:0]    id_s    [QUE_SIZE];
    logic [PRI_WIDTH-1:0]   pri_s   [QUE_SIZE];
    logic                   valid_s [QUE_SIZE];

    logic [QUE_SIZE-1:0]    ahead;   // new entry goes in front of slot
    logic [QUE_SIZE-1:0]    hit;     // slot at or behind removed id

    // ----------------------------------------------------------------------
    // apply pending per-slot moves
    // ----------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < QUE_SIZE; i++) begin
            id_s[i]    = id_q[i];
            pri_s[i]   = pri_q[i];
            valid_s[i] = valid_q[i];
            case (flag_q[i])
                FLAG_FORWARD: begin
                    id_s[i]    = id_q[(i + 1) % QUE_SIZE];
                    pri_s[i]   = pri_q[(i + 1) % QUE_SIZE];
                    valid_s[i] = (i < QUE_SIZE - 1) && valid_q[(i + 1) % QUE_SIZE];
                end
                FLAG_BACKWARD: begin   // never on slot 0
                    id_s[i]    = id_q[(i + QUE_SIZE - 1) % QUE_SIZE];
                    pri_s[i]   = pri_q[(i + QUE_SIZE - 1) % QUE_SIZE];
                    valid_s[i] = valid_q[(i + QUE_SIZE - 1) % QUE_SIZE];
                end
                FLAG_INSERT: begin
                    id_s[i]    = ins_id_q;
                    pri_s[i]   = ins_pri_q;
                    valid_s[i] = 1'b1;
                end
                default: ;
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < QUE_SIZE; i++) begin
            ahead[i] = !valid_s[i] || (q.add_pri < pri_s[i]);
        end
        hit[0] = valid_s[0] && (id_s[0] == q.remove_id);
        for (int i = 1; i < QUE_SIZE; i++) begin
            hit[i] = hit[i-1] || (valid_s[i] && (id_s[i] == q.remove_id));
        end
    end

    // ----------------------------------------------------------------------
    // update
    // ----------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            count_q <= '0;
            for (int i = 0; i < QUE_SIZE; i++) begin
                valid_q[i] <= 1'b0;
                flag_q[i]  <= FLAG_STAY;
            end
        end else begin
            for (int i = 0; i < QUE_SIZE; i++) begin
                id_q[i]    <= id_s[i];
                pri_q[i]   <= pri_s[i];
                valid_q[i] <= valid_s[i];
                flag_q[i]  <= FLAG_STAY;
            end
            ins_id_q  <= q.add_id;
            ins_pri_q <= q.add_pri;

            if (q.add_valid) begin
                count_q <= count_q + 1'b1;
                for (int i = 1; i < QUE_SIZE; i++) begin
                    if (ahead[i]) begin
                        flag_q[i] <= ahead[i-1] ? FLAG_BACKWARD : FLAG_INSERT;
                    end
                end
                if (ahead[0]) begin
                    // new head right away, old head drops into slot 1
                    id_q[0]    <= q.add_id;
                    pri_q[0]   <= q.add_pri;
                    valid_q[0] <= 1'b1;
                    ins_id_q   <= id_s[0];
                    ins_pri_q  <= pri_s[0];
                    flag_q[1]  <= valid_s[0] ? FLAG_INSERT : FLAG_STAY;
                end
            end else if (q.remove_valid) begin
                for (int i = 1; i < QUE_SIZE; i++) begin
                    if (hit[i]) begin
                        flag_q[i] <= FLAG_FORWARD;
                    end
                end
                if (hit[0]) begin
                    id_q[0]    <= id_s[1];
                    pri_q[0]   <= pri_s[1];
                    valid_q[0] <= valid_s[1];
                end
                if (hit[QUE_SIZE-1]) begin   // id was present
                    count_q <= count_q - 1'b1;
                end
            end
        end
    end

    assign q.top_id    = id_q[0];
    assign q.top_pri   = pri_q[0];
    assign q.top_valid = valid_q[0];
    assign q.count     = count_q;

endmodule

`default_nettype wire

// File: timer_if.sv
// delay timer connection between dispatcher and timer
// wake_valid is a level, the id holds until the wake_ack cycle
// sleep_pri carries the task priority to be latched with the delay

`timescale 1ns/1ps
`default_nettype none

interface timer_if;
    import sched_pkg::*;

    logic [ID_WIDTH-1:0]    sleep_id;
    logic [PRI_WIDTH-1:0]   sleep_pri;
    logic [DELAY_WIDTH-1:0] sleep_delay;
    logic                   sleep_valid;
    logic [ID_WIDTH-1:0]    wake_id;
    logic [PRI_WIDTH-1:0]   wake_pri;
    logic                   wake_valid;
    logic                   wake_ack;

    modport dispatch (
        output sleep_id, sleep_pri, sleep_delay, sleep_valid, wake_ack,
        input  wake_id, wake_pri, wake_valid
    );

    modport timer (
        input  sleep_id, sleep_pri, sleep_delay, sleep_valid, wake_ack,
        output wake_id, wake_pri, wake_valid
    );

endinterface

`default_nettype wire

// File: queue_if.sv
// ready queue connection between dispatcher and queue
// add and remove are single-cycle strobes without acknowledge
// add wins when both strobes are high together

`timescale 1ns/1ps
`default_nettype none

interface queue_if;
    import sched_pkg::*;

    logic [ID_WIDTH-1:0]    add_id;
    logic [PRI_WIDTH-1:0]   add_pri;
    logic                   add_valid;
    logic [ID_WIDTH-1:0]    remove_id;
    logic                   remove_valid;
    logic [ID_WIDTH-1:0]    top_id;
    logic [PRI_WIDTH-1:0]   top_pri;
    logic                   top_valid;
    logic [COUNT_WIDTH-1:0] count;

    modport dispatch (
        output add_id, add_pri, add_valid, remove_id, remove_valid
    );

    modport queue (
        input  add_id, add_pri, add_valid, remove_id, remove_valid,
        output top_id, top_pri, top_valid, count
    );

endinterface

`default_nettype wire

// File: sched_pkg.sv
// shared sizes, op codes and command word for the task scheduler
// sizes are fixed to 16 task ids, queue depth equals the task count
// command word: [15:14] op, [13:10] id, then pri or delay below that
// priority: lower value is more urgent

`default_nettype none

package sched_pkg;

    localparam int QUE_SIZE    = 16;
    localparam int ID_WIDTH    = 4;
    localparam int PRI_WIDTH   = 4;
    localparam int DELAY_WIDTH = 10;
    localparam int COUNT_WIDTH = 5;
    localparam int CMD_WIDTH   = 16;

    // op codes, top two bits of the command word
    localparam logic [1:0] OP_NOP   = 2'd0;
    localparam logic [1:0] OP_READY = 2'd1;
    localparam logic [1:0] OP_SLEEP = 2'd2;
    localparam logic [1:0] OP_EXIT  = 2'd3;

    // ready queue per-slot shift flags
    localparam logic [1:0] FLAG_STAY     = 2'd0;
    localparam logic [1:0] FLAG_FORWARD  = 2'd1;
    localparam logic [1:0] FLAG_BACKWARD = 2'd2;
    localparam logic [1:0] FLAG_INSERT   = 2'd3;

    // ----------------------------------------------------------------------
    // command word, same op/id bits in both views
    // ----------------------------------------------------------------------
    typedef union packed {
        struct packed {
            logic [1:0]           op;
            logic [ID_WIDTH-1:0]  id;
            logic [PRI_WIDTH-1:0] pri;   // ignored by EXIT
            logic [5:0]           rsvd;
        } rdy;
        struct packed {
            logic [1:0]             op;
            logic [ID_WIDTH-1:0]    id;
            logic [DELAY_WIDTH-1:0] delay;
        } slp;
    } sched_cmd_t;

endpackage

`default_nettype wire
